// File: hw/main_mem_pkg.sv
`default_nettype none

package main_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_BANKS   = 8;
  localparam int BANK_DEPTH  = 512;   // words per bank
  localparam int WORD_W      = 64;
  localparam int WORD_ADDR_W = 9;
  localparam int BANK_SEL_W  = 3;
  localparam int INDEX_W     = 14;    // linear element index on the ports

  ////////////////////////////////////////////////////////////////////////////
  // region layout, word offsets inside every bank
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [WORD_ADDR_W-1:0] B_ROW_WORDS = 9'd336;
  localparam logic [WORD_ADDR_W-1:0] OFF_B       = 9'd0;
  localparam logic [WORD_ADDR_W-1:0] OFF_S       = OFF_B + B_ROW_WORDS;  // reserved
  localparam logic [WORD_ADDR_W-1:0] OFF_SSSTATE = OFF_S + 9'd84;
  localparam logic [WORD_ADDR_W-1:0] OFF_C       = OFF_SSSTATE + 9'd4;
  localparam logic [WORD_ADDR_W-1:0] OFF_RNG     = OFF_C + 9'd2;
  localparam logic [WORD_ADDR_W-1:0] OFF_SALT    = OFF_RNG + 9'd1;
  localparam logic [WORD_ADDR_W-1:0] OFF_SEEDSE  = OFF_SALT + 9'd1;
  localparam logic [WORD_ADDR_W-1:0] OFF_PKH     = OFF_SEEDSE + 9'd1;
  localparam logic [WORD_ADDR_W-1:0] OFF_U       = OFF_PKH + 9'd1;       // reserved
  localparam logic [WORD_ADDR_W-1:0] OFF_K       = OFF_U + 9'd1;

  // last valid index of each region
  localparam logic [INDEX_W-1:0] LAST_B_ROW   = 14'd3919;  // bank 7, word 335
  localparam logic [INDEX_W-1:0] LAST_C_ROW   = 14'd15;
  localparam logic [INDEX_W-1:0] LAST_SSSTATE = 14'd24;
  localparam logic [INDEX_W-1:0] LAST_RNG     = 14'd7;
  localparam logic [INDEX_W-1:0] LAST_SALT    = 14'd7;
  localparam logic [INDEX_W-1:0] LAST_SEEDSE  = 14'd7;
  localparam logic [INDEX_W-1:0] LAST_PKH     = 14'd3;
  localparam logic [INDEX_W-1:0] LAST_K       = 14'd3;

  typedef enum logic [3:0] {
    CMD_NONE,
    CMD_B_ROW,    // matrix B, row first
    CMD_C_ROW,    // matrix C, row first
    CMD_SSSTATE,
    CMD_RNG,
    CMD_SALT,
    CMD_SEEDSE,
    CMD_PKH,
    CMD_K
  } mem_cmd_e;

  typedef struct packed {
    logic                   en;
    logic [BANK_SEL_W-1:0]  bank;
    logic [WORD_ADDR_W-1:0] word;
  } bank_req_t;

endpackage

`default_nettype wire

// File: hw/bram_bank.sv
`default_nettype none

module bram_bank import main_mem_pkg::*; (
  input  logic                   clk,
  input  logic                   i_rd_en,
  input  logic [WORD_ADDR_W-1:0] i_rd_word,
  input  logic                   i_wr_en,
  input  logic [WORD_ADDR_W-1:0] i_wr_word,
  input  logic [WORD_W-1:0]      i_wr_data,
  output logic [WORD_W-1:0]      o_rd_data
);

  logic [WORD_W-1:0] mem [BANK_DEPTH];
  logic [WORD_W-1:0] rd_q1;   // ram latch
  logic [WORD_W-1:0] rd_q2;   // output register

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_word] <= i_wr_data;
    end
  end

  // same-edge read sees the old word
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_word];
    end
  end

  always_ff @(posedge clk) begin
    rd_q2 <= rd_q1;
  end

  assign o_rd_data = rd_q2;

endmodule

`default_nettype wire

// File: hw/bank_array.sv
`default_nettype none

module bank_array import main_mem_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  input  bank_req_t         i_rd_req,
  input  bank_req_t         i_wr_req,
  input  logic [WORD_W-1:0] i_wr_data,
  output logic [WORD_W-1:0] o_rd_data
);

  logic [NUM_BANKS-1:0] rd_sel;
  logic [NUM_BANKS-1:0] wr_sel;
  logic [NUM_BANKS-1:0] rd_sel_q1;
  logic [NUM_BANKS-1:0] rd_sel_q2;
  logic [WORD_W-1:0]    bank_rd_data [NUM_BANKS];

  ////////////////////////////////////////////////////////////////////////////
  // banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    assign rd_sel[g] = i_rd_req.en && (i_rd_req.bank == BANK_SEL_W'(g));
    assign wr_sel[g] = i_wr_req.en && (i_wr_req.bank == BANK_SEL_W'(g));

    bram_bank u_bank (
      .clk       (clk),
      .i_rd_en   (rd_sel[g]),
      .i_rd_word (i_rd_req.word),
      .i_wr_en   (wr_sel[g]),
      .i_wr_word (i_wr_req.word),
      .i_wr_data (i_wr_data),      // same word to every bank
      .o_rd_data (bank_rd_data[g])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // read select pipeline and merge
  ////////////////////////////////////////////////////////////////////////////

  // follows the two ram stages
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_sel_q1 <= '0;
      rd_sel_q2 <= '0;
    end else begin
      rd_sel_q1 <= rd_sel;
      rd_sel_q2 <= rd_sel_q1;
    end
  end

  // zero when no read was in flight
  always_comb begin
    o_rd_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      o_rd_data = o_rd_data | (bank_rd_data[b] & {WORD_W{rd_sel_q2[b]}});
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_addr_map.sv
`default_nettype none

module mem_addr_map import main_mem_pkg::*; (
  input  mem_cmd_e           i_cmd,
  input  logic [INDEX_W-1:0] i_index,
  output bank_req_t          o_req,
  output logic [INDEX_W-1:0] o_next,
  output logic               o_last
);

  logic                   is_b_row;
  logic                   is_c_row;
  logic                   is_cell;
  logic                   hit;
  logic                   b_wrap;
  logic [WORD_ADDR_W-1:0] cell_off;
  logic [INDEX_W-1:0]     last_idx;
  logic [INDEX_W-1:0]     index_inc;

  assign is_b_row  = (i_cmd == CMD_B_ROW);
  assign is_c_row  = (i_cmd == CMD_C_ROW);
  assign hit       = is_b_row | is_c_row | is_cell;
  assign index_inc = i_index + 1'b1;
  assign b_wrap    = (i_index[WORD_ADDR_W-1:0] == B_ROW_WORDS - 9'd1);  // word 335

  ////////////////////////////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    is_cell  = 1'b1;
    cell_off = '0;
    last_idx = '0;
    case (i_cmd)
      CMD_B_ROW: begin
        is_cell  = 1'b0;
        last_idx = LAST_B_ROW;
      end
      CMD_C_ROW: begin
        is_cell  = 1'b0;
        last_idx = LAST_C_ROW;
      end
      CMD_SSSTATE: begin
        cell_off = OFF_SSSTATE;
        last_idx = LAST_SSSTATE;
      end
      CMD_RNG: begin
        cell_off = OFF_RNG;
        last_idx = LAST_RNG;
      end
      CMD_SALT: begin
        cell_off = OFF_SALT;
        last_idx = LAST_SALT;
      end
      CMD_SEEDSE: begin
        cell_off = OFF_SEEDSE;
        last_idx = LAST_SEEDSE;
      end
      CMD_PKH: begin
        cell_off = OFF_PKH;
        last_idx = LAST_PKH;
      end
      CMD_K: begin
        cell_off = OFF_K;
        last_idx = LAST_K;
      end
      default: begin
        is_cell = 1'b0;     // idle or unused code
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // bank and word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    o_req    = '0;
    o_req.en = hit;
    if (is_b_row) begin
      o_req.bank = i_index[WORD_ADDR_W +: BANK_SEL_W];
      o_req.word = OFF_B + i_index[WORD_ADDR_W-1:0];
    end else if (is_c_row) begin
      // odd elements land one bank over
      o_req.bank = i_index[BANK_SEL_W:1] ^ {{(BANK_SEL_W-1){1'b0}}, i_index[0]};
      o_req.word = OFF_C + {{(WORD_ADDR_W-1){1'b0}}, i_index[0]};
    end else if (is_cell) begin
      o_req.bank = i_index[BANK_SEL_W-1:0];
      o_req.word = cell_off + i_index[BANK_SEL_W +: WORD_ADDR_W];
    end
  end

  assign o_next = !hit ? '0 :
                  (is_b_row && b_wrap) ?
                    {i_index[INDEX_W-1:WORD_ADDR_W] + 1'b1, {WORD_ADDR_W{1'b0}}} :
                    index_inc;

  assign o_last = hit && (i_index == last_idx);

endmodule

`default_nettype wire

// File: hw/main_mem.sv
`default_nettype none

module main_mem import main_mem_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,

  // read port
  input  mem_cmd_e           i_rd_cmd,
  input  logic [INDEX_W-1:0] i_rd_index,
  output logic [WORD_W-1:0]  o_rd_data,   // two cycles after the strobe
  output logic [INDEX_W-1:0] o_rd_next,
  output logic               o_rd_last,

  // write port
  input  mem_cmd_e           i_wr_cmd,
  input  logic [INDEX_W-1:0] i_wr_index,
  input  logic [WORD_W-1:0]  i_wr_data,
  output logic [INDEX_W-1:0] o_wr_next,
  output logic               o_wr_last
);

  bank_req_t rd_req;
  bank_req_t wr_req;

  ////////////////////////////////////////////////////////////////////////////
  // port mappers
  ////////////////////////////////////////////////////////////////////////////

  mem_addr_map u_rd_map (
    .i_cmd   (i_rd_cmd),
    .i_index (i_rd_index),
    .o_req   (rd_req),
    .o_next  (o_rd_next),
    .o_last  (o_rd_last)
  );

  mem_addr_map u_wr_map (
    .i_cmd   (i_wr_cmd),
    .i_index (i_wr_index),
    .o_req   (wr_req),
    .o_next  (o_wr_next),
    .o_last  (o_wr_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  bank_array u_banks (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_rd_req  (rd_req),
    .i_wr_req  (wr_req),
    .i_wr_data (i_wr_data),
    .o_rd_data (o_rd_data)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_checker.sv
`default_nettype none

module tb_checker import main_mem_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic [7:0]         i_test,
  input  logic               i_rd,        // read issued this cycle
  input  logic               i_wr,        // write issued this cycle
  input  logic [INDEX_W-1:0] i_exp_next,
  input  logic               i_exp_last,
  input  logic [WORD_W-1:0]  i_exp_data,
  input  logic               i_test_end,
  input  logic [WORD_W-1:0]  i_rd_data,
  input  logic [INDEX_W-1:0] i_rd_next,
  input  logic               i_rd_last,
  input  logic [INDEX_W-1:0] i_wr_next,
  input  logic               i_wr_last,
  output int                 o_tests_run,
  output int                 o_tests_failed,
  output int                 o_errors
);

  logic [WORD_W-1:0] exp_q [2];
  logic [7:0]        tag_q [2];
  logic [1:0]        live_q;
  int                test_errs [256] = '{default: 0};
  int                tests_run = 0;
  int                tests_failed = 0;
  int                errors = 0;

  assign o_tests_run    = tests_run;
  assign o_tests_failed = tests_failed;
  assign o_errors       = errors;

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act,
                         input logic [7:0] test);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h (test %0d)", $time, name, exp, act,
               test);
      test_errs[test]++;
      errors++;
    end
  endtask

  task automatic report_test(input logic [7:0] test);
    tests_run++;
    if (test_errs[test] != 0) begin
      tests_failed++;
    end
    $display("test %0d %s, %0d errors", test, (test_errs[test] == 0) ? "ok" : "failed",
             test_errs[test]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampled mid-cycle, away from the driving edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!i_rst_n) begin
      live_q <= '0;
      compare("o_rd_data", '0, i_rd_data, 8'd0);   // select pipe cleared
    end else begin
      if (live_q[1]) begin
        compare("o_rd_data", exp_q[1], i_rd_data, tag_q[1]);
      end
      compare("o_rd_next", 64'(i_rd ? i_exp_next : '0), 64'(i_rd_next), i_test);
      compare("o_rd_last", 64'(i_rd & i_exp_last), 64'(i_rd_last), i_test);
      compare("o_wr_next", 64'(i_wr ? i_exp_next : '0), 64'(i_wr_next), i_test);
      compare("o_wr_last", 64'(i_wr & i_exp_last), 64'(i_wr_last), i_test);
      exp_q[1] <= exp_q[0];
      exp_q[0] <= i_rd ? i_exp_data : '0;   // idle port reads back zero
      tag_q[1] <= tag_q[0];
      tag_q[0] <= i_test;
      live_q   <= {live_q[0], 1'b1};
      if (i_test_end) begin
        report_test(i_test);
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_main_mem.sv
`default_nettype none

module tb_main_mem import main_mem_pkg::*; ();

  localparam int GOLD_COLS  = 8;
  localparam int GOLD_LINES = 64;
  localparam int DRAIN      = 3;   // idle cycles until the last read is checked

  logic               clk;
  logic               rst_n;
  mem_cmd_e           rd_cmd;
  logic [INDEX_W-1:0] rd_index;
  mem_cmd_e           wr_cmd;
  logic [INDEX_W-1:0] wr_index;
  logic [WORD_W-1:0]  wr_data;
  logic [WORD_W-1:0]  rd_data;
  logic [INDEX_W-1:0] rd_next;
  logic               rd_last;
  logic [INDEX_W-1:0] wr_next;
  logic               wr_last;

  logic [7:0]         chk_test;
  logic               chk_rd;
  logic               chk_wr;
  logic [INDEX_W-1:0] chk_next;
  logic               chk_last;
  logic [WORD_W-1:0]  chk_data;
  logic               chk_test_end;
  int                 tests_run;
  int                 tests_failed;
  int                 errors;

  logic [63:0] gold [GOLD_LINES*GOLD_COLS];
  int          num_lines = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  tb_clk_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

  main_mem DUT (
    .clk        (clk),
    .i_rst_n    (rst_n),
    .i_rd_cmd   (rd_cmd),
    .i_rd_index (rd_index),
    .o_rd_data  (rd_data),
    .o_rd_next  (rd_next),
    .o_rd_last  (rd_last),
    .i_wr_cmd   (wr_cmd),
    .i_wr_index (wr_index),
    .i_wr_data  (wr_data),
    .o_wr_next  (wr_next),
    .o_wr_last  (wr_last)
  );

  tb_checker u_chk (
    .clk (clk), .i_rst_n (rst_n), .i_test (chk_test), .i_rd (chk_rd), .i_wr (chk_wr),
    .i_exp_next (chk_next), .i_exp_last (chk_last), .i_exp_data (chk_data),
    .i_test_end (chk_test_end), .i_rd_data (rd_data), .i_rd_next (rd_next),
    .i_rd_last (rd_last), .i_wr_next (wr_next), .i_wr_last (wr_last),
    .o_tests_run (tests_run), .o_tests_failed (tests_failed), .o_errors (errors)
  );

  // op bit 0 drives the write port, bit 1 the read port
  task automatic drive_line(input int line);
    int         base;
    logic [3:0] op;
    mem_cmd_e   cmd;
    base = line * GOLD_COLS;
    op   = gold[base+1][3:0];
    cmd  = mem_cmd_e'(gold[base+2][3:0]);
    rd_cmd       <= op[1] ? cmd : CMD_NONE;
    rd_index     <= op[1] ? gold[base+3][INDEX_W-1:0] : '0;
    wr_cmd       <= op[0] ? cmd : CMD_NONE;
    wr_index     <= op[0] ? gold[base+3][INDEX_W-1:0] : '0;
    wr_data      <= op[0] ? gold[base+4] : '0;
    chk_test     <= gold[base][7:0];
    chk_rd       <= op[1];
    chk_wr       <= op[0];
    chk_data     <= gold[base+5];
    chk_next     <= gold[base+6][INDEX_W-1:0];
    chk_last     <= gold[base+7][0];
    chk_test_end <= 1'b0;
  endtask

  task automatic drain_test();
    for (int i = 0; i < DRAIN; i++) begin
      @(posedge clk);
      rd_cmd       <= CMD_NONE;
      wr_cmd       <= CMD_NONE;
      chk_rd       <= 1'b0;
      chk_wr       <= 1'b0;
      chk_test_end <= (i == DRAIN - 1);   // last read of the test checked here
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rd_cmd       = CMD_NONE;
    rd_index     = '0;
    wr_cmd       = CMD_NONE;
    wr_index     = '0;
    wr_data      = '0;
    chk_test     = '0;
    chk_rd       = 1'b0;
    chk_wr       = 1'b0;
    chk_next     = '0;
    chk_last     = 1'b0;
    chk_data     = '0;
    chk_test_end = 1'b0;
    $readmemh("test/main_mem_golden.txt", gold);
    while (num_lines < GOLD_LINES && gold[num_lines*GOLD_COLS + 1] != 64'hf) begin
      num_lines++;
    end
    cycle_limit = 4 * num_lines + 50;
    @(posedge rst_n);
    for (int line = 0; line < num_lines; line++) begin
      @(posedge clk);
      drive_line(line);
      if (line == num_lines - 1 || gold[(line+1)*GOLD_COLS] != gold[line*GOLD_COLS]) begin
        drain_test();
      end
    end
    @(posedge clk);
    chk_test_end <= 1'b0;
    repeat (DRAIN) @(posedge clk);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run != 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: main_mem.f
hw/main_mem_pkg.sv
hw/bram_bank.sv
hw/bank_array.sv
hw/mem_addr_map.sv
hw/main_mem.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_main_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the main_mem testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_main_mem \
  -Mdir obj_dir \
  -f main_mem.f

sim_out=$(./obj_dir/Vtb_main_mem)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: test/main_mem_golden.txt
// test op cmd index wdata rdata next last, all hex
// op 1 write, 2 read, 3 read and write together, 0 idle, f ends the list
1 1 3 0018 1111aaaa00000018 0 0019 1
1 1 4 0007 2222bbbb00000007 0 0008 1
1 1 5 0000 3333cccc00000000 0 0001 0
1 1 6 0005 4444dddd00000005 0 0006 0
1 1 8 0003 5555eeee00000003 0 0004 1
1 2 3 0018 0 1111aaaa00000018 0019 1
1 2 4 0007 0 2222bbbb00000007 0008 1
1 2 5 0000 0 3333cccc00000000 0001 0
1 2 6 0005 0 4444dddd00000005 0006 0
1 2 8 0003 0 5555eeee00000003 0004 1
2 1 1 014f b0b000000000014f 0 0200 0
2 1 1 0d4f b6b6000000000d4f 0 0e00 0
2 1 1 0f4f b7b7000000000f4f 0 1000 1
2 2 1 014f 0 b0b000000000014f 0200 0
2 2 1 0d4f 0 b6b6000000000d4f 0e00 0
2 2 1 0f4f 0 b7b7000000000f4f 1000 1
3 1 2 0000 c0c0c0c0c0c0c0c0 0 0001 0
3 1 2 0001 c1c1c1c1c1c1c1c1 0 0002 0
3 1 2 000f cfcfcfcfcfcfcfcf 0 0010 1
3 2 2 0000 0 c0c0c0c0c0c0c0c0 0001 0
3 2 2 0001 0 c1c1c1c1c1c1c1c1 0002 0
3 2 2 000f 0 cfcfcfcfcfcfcfcf 0010 1
3 2 4 0007 0 2222bbbb00000007 0008 1
4 2 5 0000 0 3333cccc00000000 0001 0
4 2 6 0005 0 4444dddd00000005 0006 0
4 2 2 0001 0 c1c1c1c1c1c1c1c1 0002 0
5 1 7 0003 d0d0d0d0d0d0d0d0 0 0004 1
5 3 7 0003 d1d1d1d1d1d1d1d1 d0d0d0d0d0d0d0d0 0004 1
5 0 0 0000 0 0 0000 0
5 2 7 0003 0 d1d1d1d1d1d1d1d1 0004 1
0 f 0 0000 0 0 0000 0
